/* logic/ifu_consts.svh */
//--------------------------------------------------------------------
// IFU constants
// Bus widths, halfword queue geometry and transaction counter size
//--------------------------------------------------------------------
`ifndef IFU_CONSTS_SVH
`define IFU_CONSTS_SVH

// Bus widths
`define IFU_XLEN        32          // Address width
`define IFU_DWIDTH      32          // Memory data width
`define IFU_HWIDTH      16          // One halfword

// Instruction queue
`define IFU_Q_HALVES    4           // Depth in halfwords
`define IFU_Q_PTR_W     3           // Index plus wrap bit
`define IFU_Q_FREE_W    3           // Holds 0 to 4

// Up to 7 transactions in flight
`define IFU_TXN_CNT_W   3

`endif

/* logic/ifu_pkg.sv */
//--------------------------------------------------------------------
// IFU package
// State, response and queue-write encodings plus the bundled buses
//--------------------------------------------------------------------
`default_nettype none
`include "ifu_consts.svh"

package ifu_pkg;

    typedef enum logic {
        fsm_idle,
        fsm_fetch
    } fetch_state_e;

    typedef enum logic [1:0] {
        resp_none,
        resp_rdy_ok,
        resp_rdy_er
    } mem_resp_e;

    typedef enum logic [1:0] {
        we_none,
        we_hi,                              // Upper 16 bits only
        we_full                             // Whole word
    } q_we_e;

    typedef enum logic {
        rdata_rvi_part2,                    // Lower half ends a 32-bit instruction
        rdata_other
    } rdata_type_e;

    // Named as <upper half>_<lower half>
    typedef enum logic [2:0] {
        ident_none,
        ident_rvi_hi_rvi_lo,
        ident_rvc_rvc,
        ident_rvi_lo_rvc,
        ident_rvc_rvi_hi,
        ident_rvi_lo_rvi_hi,
        ident_rvc_nv,                       // Lower half skipped after unaligned jump
        ident_rvi_lo_nv
    } rdata_ident_e;

    typedef struct packed {
        mem_resp_e                  resp;
        logic [`IFU_DWIDTH-1:0]     rdata;
    } imem_resp_t;

    typedef struct packed {
        q_we_e                      we;
        logic [`IFU_DWIDTH-1:0]     data;
        logic                       err;
    } q_write_t;

    typedef struct packed {
        logic [`IFU_DWIDTH-1:0]     instr;
        logic                       imem_err;
        logic                       err_rvi_hi;     // Fault on the second half only
    } fetch_instr_t;

endpackage : ifu_pkg

`default_nettype wire

/* logic/fetch_req_ctrl.sv */
//--------------------------------------------------------------------
// Fetch request control
// Idle/fetch FSM, word address generation, pending and discard counts
//--------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "ifu_consts.svh"

module fetch_req_ctrl (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        new_pc_req,     // Jump, branch or trap
    input  logic [`IFU_XLEN-1:0]        new_pc,
    input  logic                        stop_fetch,
    input  logic                        imem_req_ack,
    input  ifu_pkg::imem_resp_t         imem_resp,
    input  logic [`IFU_Q_FREE_W-1:0]    free_words,     // After this cycle's read
    output logic                        imem_req,
    output logic [`IFU_XLEN-1:0]        imem_addr,
    output logic                        resp_accept,    // Response goes to the queue
    output logic                        flush,
    output logic                        ifu_busy
);

    ifu_pkg::fetch_state_e          state;
    logic [`IFU_XLEN-1:2]           addr_r;
    logic [`IFU_XLEN-1:2]           addr_base;
    logic [`IFU_TXN_CNT_W-1:0]      pend_cnt;           // Sent, not yet answered
    logic [`IFU_TXN_CNT_W-1:0]      pend_cnt_new;
    logic [`IFU_TXN_CNT_W-1:0]      disc_cnt;           // Answers still to drop
    logic [`IFU_TXN_CNT_W-1:0]      disc_cnt_new;
    logic [`IFU_TXN_CNT_W-1:0]      vd_pend_cnt;
    logic [`IFU_TXN_CNT_W-1:0]      req_inc;
    logic [`IFU_TXN_CNT_W-1:0]      resp_dec;
    logic                           req_acc;
    logic                           resp_is_ok;
    logic                           resp_is_er;
    logic                           resp_vld;
    logic                           discard;
    logic                           pend_full;

    //----------------------------------------------------------------
    // Memory request
    //----------------------------------------------------------------
    assign flush     = new_pc_req | stop_fetch;
    assign pend_full = &pend_cnt;

    // Room in the queue must cover every answer that will be kept
    assign imem_req = ~pend_full & ~stop_fetch
                    & (new_pc_req | ((state == ifu_pkg::fsm_fetch) & (free_words > vd_pend_cnt)));

    assign addr_base = new_pc_req ? new_pc[`IFU_XLEN-1:2] : addr_r;
    assign imem_addr = {addr_base, 2'b00};
    assign req_acc   = imem_req & imem_req_ack;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            addr_r <= '0;
        end else if (req_acc) begin
            addr_r <= addr_base + 1'b1;             // Next word after the one sent
        end else if (new_pc_req) begin
            addr_r <= new_pc[`IFU_XLEN-1:2];
        end
    end

    //----------------------------------------------------------------
    // Pending and discard counters
    //----------------------------------------------------------------
    assign resp_is_ok  = (imem_resp.resp == ifu_pkg::resp_rdy_ok);
    assign resp_is_er  = (imem_resp.resp == ifu_pkg::resp_rdy_er);
    assign resp_vld    = resp_is_ok | resp_is_er;
    assign discard     = |disc_cnt;
    assign resp_accept = resp_vld & ~discard;
    assign vd_pend_cnt = pend_cnt - disc_cnt;

    assign req_inc      = {{(`IFU_TXN_CNT_W-1){1'b0}}, req_acc};
    assign resp_dec     = {{(`IFU_TXN_CNT_W-1){1'b0}}, resp_vld};
    assign pend_cnt_new = pend_cnt + req_inc - resp_dec;

    always_comb begin
        if (flush) begin
            disc_cnt_new = pend_cnt_new - req_inc;  // Keep only this cycle's request
        end else if (resp_is_er & ~discard) begin
            disc_cnt_new = pend_cnt_new;            // Drop all after a fault
        end else if (resp_vld & discard) begin
            disc_cnt_new = disc_cnt - 1'b1;
        end else begin
            disc_cnt_new = disc_cnt;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pend_cnt <= '0;
            disc_cnt <= '0;
        end else begin
            pend_cnt <= pend_cnt_new;
            disc_cnt <= disc_cnt_new;
        end
    end

    //----------------------------------------------------------------
    // FSM
    //----------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ifu_pkg::fsm_idle;
        end else begin
            case (state)
                ifu_pkg::fsm_idle: begin
                    if (new_pc_req & ~stop_fetch) begin
                        state <= ifu_pkg::fsm_fetch;
                    end
                end
                ifu_pkg::fsm_fetch: begin
                    if (stop_fetch | (resp_is_er & ~discard & ~new_pc_req)) begin
                        state <= ifu_pkg::fsm_idle;
                    end
                end
            endcase
        end
    end

    assign ifu_busy = (state == ifu_pkg::fsm_fetch);

endmodule : fetch_req_ctrl

`default_nettype wire

/* logic/rdata_classifier.sv */
//--------------------------------------------------------------------
// Response classifier
// Sorts each kept memory word into RVC/RVI halves, issues queue writes
//--------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "ifu_consts.svh"

module rdata_classifier (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    new_pc_req,
    input  logic                    new_pc_lo,      // Target is the upper halfword
    input  logic                    resp_accept,
    input  ifu_pkg::imem_resp_t     imem_resp,
    output ifu_pkg::q_write_t       q_write
);

    ifu_pkg::rdata_type_e       rdata_curr;
    ifu_pkg::rdata_type_e       rdata_next;
    ifu_pkg::rdata_ident_e      ident;
    logic                       start_hi;           // First word after unaligned jump
    logic                       resp_is_ok;
    logic                       resp_is_er;
    logic                       lo_rvi;
    logic                       hi_rvi;

    assign resp_is_ok = (imem_resp.resp == ifu_pkg::resp_rdy_ok);
    assign resp_is_er = (imem_resp.resp == ifu_pkg::resp_rdy_er);
    assign lo_rvi     = &imem_resp.rdata[1:0];
    assign hi_rvi     = &imem_resp.rdata[`IFU_HWIDTH+1:`IFU_HWIDTH];

    always_comb begin
        ident = ifu_pkg::ident_none;
        if (resp_is_ok & resp_accept) begin
            if (start_hi) begin
                ident = hi_rvi ? ifu_pkg::ident_rvi_lo_nv : ifu_pkg::ident_rvc_nv;
            end else if (rdata_curr == ifu_pkg::rdata_rvi_part2) begin
                ident = hi_rvi ? ifu_pkg::ident_rvi_lo_rvi_hi : ifu_pkg::ident_rvc_rvi_hi;
            end else if (lo_rvi) begin
                ident = ifu_pkg::ident_rvi_hi_rvi_lo;
            end else begin
                ident = hi_rvi ? ifu_pkg::ident_rvi_lo_rvc : ifu_pkg::ident_rvc_rvc;
            end
        end
    end

    // Upper half opens an RVI whose second half comes in the next word
    assign rdata_next = ((ident == ifu_pkg::ident_rvi_lo_nv)
                       | (ident == ifu_pkg::ident_rvi_lo_rvi_hi)
                       | (ident == ifu_pkg::ident_rvi_lo_rvc))
                      ? ifu_pkg::rdata_rvi_part2 : ifu_pkg::rdata_other;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            start_hi   <= 1'b0;
            rdata_curr <= ifu_pkg::rdata_other;
        end else if (new_pc_req) begin
            start_hi   <= new_pc_lo;
            rdata_curr <= ifu_pkg::rdata_other;
        end else if (resp_accept) begin
            start_hi   <= 1'b0;
            rdata_curr <= rdata_next;
        end
    end

    always_comb begin
        q_write.we   = ifu_pkg::we_none;
        q_write.data = imem_resp.rdata;
        q_write.err  = resp_is_er;
        if (resp_accept) begin
            if (resp_is_er) begin
                q_write.we = ifu_pkg::we_full;      // Both halves carry the fault
            end else begin
                case (ident)
                    ifu_pkg::ident_none:      q_write.we = ifu_pkg::we_none;
                    ifu_pkg::ident_rvc_nv,
                    ifu_pkg::ident_rvi_lo_nv: q_write.we = ifu_pkg::we_hi;
                    default:                  q_write.we = ifu_pkg::we_full;
                endcase
            end
        end
    end

endmodule : rdata_classifier

`default_nettype wire

/* logic/instr_queue.sv */
//--------------------------------------------------------------------
// Instruction queue
// Four-halfword buffer that presents one RVC or RVI instruction to decode
//--------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "ifu_consts.svh"

module instr_queue (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        flush,
    input  ifu_pkg::q_write_t           q_write,
    input  logic                        idu_rdy,
    output logic [`IFU_Q_FREE_W-1:0]    free_words,
    output ifu_pkg::fetch_instr_t       instr,
    output logic                        instr_vd
);

    logic [`IFU_HWIDTH-1:0]     q_data [`IFU_Q_HALVES];
    logic                       q_err  [`IFU_Q_HALVES];
    logic [`IFU_Q_PTR_W-1:0]    rptr;
    logic [`IFU_Q_PTR_W-1:0]    wptr;
    logic [`IFU_Q_PTR_W-1:0]    rptr_next;
    logic [`IFU_Q_PTR_W-1:0]    wptr_next;
    logic [`IFU_Q_PTR_W-1:0]    occ_h;              // Occupied halfwords
    logic [`IFU_Q_FREE_W-1:0]   free_h;
    logic [`IFU_Q_PTR_W-2:0]    head_idx;
    logic [`IFU_Q_PTR_W-2:0]    next_idx;
    logic [`IFU_Q_PTR_W-2:0]    wr_idx;
    logic [`IFU_HWIDTH-1:0]     head_data;
    logic [`IFU_HWIDTH-1:0]     next_data;
    logic                       head_err;
    logic                       next_err;
    logic                       head_rvi;
    logic                       q_empty;
    logic                       rd_en;
    logic                       rd_half;            // Consume one halfword only

    //----------------------------------------------------------------
    // Head of queue
    //----------------------------------------------------------------
    assign q_empty   = (rptr == wptr);
    assign occ_h     = wptr - rptr;
    assign head_idx  = rptr[`IFU_Q_PTR_W-2:0];
    assign next_idx  = head_idx + 1'b1;
    assign head_data = q_data[head_idx];
    assign next_data = q_data[next_idx];
    assign head_err  = q_err[head_idx];
    assign next_err  = q_err[next_idx];
    assign head_rvi  = &head_data[1:0];

    always_comb begin
        instr_vd         = 1'b0;
        instr.imem_err   = 1'b0;
        instr.err_rvi_hi = 1'b0;
        instr.instr      = head_rvi ? {next_data, head_data}
                                    : {{(`IFU_DWIDTH-`IFU_HWIDTH){1'b0}}, head_data};
        if (!q_empty) begin
            if (occ_h == `IFU_Q_PTR_W'(1)) begin
                // A lone RVI half waits for its partner unless it faulted
                instr_vd       = ~head_rvi | head_err;
                instr.imem_err = head_err;
            end else begin
                instr_vd         = 1'b1;
                instr.imem_err   = head_err | (head_rvi & next_err);
                instr.err_rvi_hi = ~head_err & head_rvi & next_err;
            end
        end
    end

    //----------------------------------------------------------------
    // Pointers and free space
    //----------------------------------------------------------------
    assign rd_en   = instr_vd & idu_rdy;
    assign rd_half = ~head_rvi | head_err;
    assign wr_idx  = wptr[`IFU_Q_PTR_W-2:0];

    always_comb begin
        rptr_next = rptr;
        wptr_next = wptr;
        if (rd_en) begin
            rptr_next = rptr + (rd_half ? `IFU_Q_PTR_W'(1) : `IFU_Q_PTR_W'(2));
        end
        case (q_write.we)
            ifu_pkg::we_hi:   wptr_next = wptr + `IFU_Q_PTR_W'(1);
            ifu_pkg::we_full: wptr_next = wptr + `IFU_Q_PTR_W'(2);
            default:          wptr_next = wptr;
        endcase
    end

    assign free_h     = `IFU_Q_FREE_W'(`IFU_Q_HALVES) - `IFU_Q_FREE_W'(wptr - rptr_next);
    assign free_words = free_h >> 1;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rptr <= '0;
            wptr <= '0;
        end else if (flush) begin
            rptr <= '0;                             // Empty on the next cycle
            wptr <= '0;
        end else begin
            rptr <= rptr_next;
            wptr <= wptr_next;
        end
    end

    //----------------------------------------------------------------
    // Storage
    //----------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!flush) begin
            case (q_write.we)
                ifu_pkg::we_hi: begin
                    q_data[wr_idx] <= q_write.data[`IFU_DWIDTH-1:`IFU_HWIDTH];
                    q_err[wr_idx]  <= q_write.err;
                end
                ifu_pkg::we_full: begin
                    q_data[wr_idx]        <= q_write.data[`IFU_HWIDTH-1:0];
                    q_err[wr_idx]         <= q_write.err;
                    q_data[wr_idx + 1'b1] <= q_write.data[`IFU_DWIDTH-1:`IFU_HWIDTH];
                    q_err[wr_idx + 1'b1]  <= q_write.err;
                end
                default: begin
                end
            endcase
        end
    end

endmodule : instr_queue

`default_nettype wire

/* logic/ifu_top.sv */
//--------------------------------------------------------------------
// Instruction fetch unit
// Request control, response classifier and halfword queue
//--------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "ifu_consts.svh"

module ifu_top (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    new_pc_req,
    input  logic [`IFU_XLEN-1:0]    new_pc,
    input  logic                    stop_fetch,
    input  logic                    imem_req_ack,
    input  ifu_pkg::imem_resp_t     imem_resp,
    output logic                    imem_req,
    output logic [`IFU_XLEN-1:0]    imem_addr,
    input  logic                    idu_rdy,
    output ifu_pkg::fetch_instr_t   instr,
    output logic                    instr_vd,
    output logic                    ifu_busy
);

    logic                           resp_accept;
    logic                           flush;
    logic [`IFU_Q_FREE_W-1:0]       free_words;
    ifu_pkg::q_write_t              q_write;

    fetch_req_ctrl fetch_req_ctrl_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .new_pc_req   (new_pc_req),
        .new_pc       (new_pc),
        .stop_fetch   (stop_fetch),
        .imem_req_ack (imem_req_ack),
        .imem_resp    (imem_resp),
        .free_words   (free_words),
        .imem_req     (imem_req),
        .imem_addr    (imem_addr),
        .resp_accept  (resp_accept),
        .flush        (flush),
        .ifu_busy     (ifu_busy)
    );

    rdata_classifier rdata_classifier_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .new_pc_req   (new_pc_req),
        .new_pc_lo    (new_pc[1]),                  // Halfword select of the target
        .resp_accept  (resp_accept),
        .imem_resp    (imem_resp),
        .q_write      (q_write)
    );

    instr_queue instr_queue_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .flush        (flush),
        .q_write      (q_write),
        .idu_rdy      (idu_rdy),
        .free_words   (free_words),
        .instr        (instr),
        .instr_vd     (instr_vd)
    );

endmodule : ifu_top

`default_nettype wire

/* tests/ifu_tb.sv */
//--------------------------------------------------------------------
// IFU testbench
// Random memory latency and decode stalls, expected stream from a file
//--------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "ifu_consts.svh"

module ifu_tb;

    localparam logic [31:0] no_addr = 32'hFFFF_FFFF;

    logic                       clk;
    logic                       rst_n;
    logic                       new_pc_req;
    logic [`IFU_XLEN-1:0]       new_pc;
    logic                       stop_fetch;
    logic                       imem_req_ack;
    ifu_pkg::imem_resp_t        imem_resp;
    logic                       imem_req;
    logic [`IFU_XLEN-1:0]       imem_addr;
    logic                       idu_rdy;
    ifu_pkg::fetch_instr_t      instr;
    logic                       instr_vd;
    logic                       ifu_busy;

    logic [31:0]                vec [128];          // Image, then test records
    logic [31:0]                pend_addr [$];      // Accepted, not yet answered
    int                         pend_due [$];
    int                         last_due;
    int unsigned                lcg_state;
    int                         cycle_cnt;
    int                         cycle_limit;
    int                         test_idx;
    int                         exp_base;
    int                         exp_cnt;
    int                         got;
    logic [31:0]                err_addr;
    logic [`IFU_XLEN-1:0]       next_addr;          // Word the next request must ask for
    logic                       hold_vd;            // Stalled last cycle
    ifu_pkg::fetch_instr_t      held_instr;
    logic                       idle_chk;

    ifu_top ifu_top_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .new_pc_req   (new_pc_req),
        .new_pc       (new_pc),
        .stop_fetch   (stop_fetch),
        .imem_req_ack (imem_req_ack),
        .imem_resp    (imem_resp),
        .imem_req     (imem_req),
        .imem_addr    (imem_addr),
        .idu_rdy      (idu_rdy),
        .instr        (instr),
        .instr_vd     (instr_vd),
        .ifu_busy     (ifu_busy)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [14:0] next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[30:16];
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Finished with errors");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input string name, input logic [33:0] expected,
                               input logic [33:0] actual);
        if (actual !== expected) begin
            abort_run($sformatf("error %s expected %h actual %h", name, expected, actual));
        end
    endtask

    //----------------------------------------------------------------
    // Per-cycle sampling at the falling edge
    //----------------------------------------------------------------
    task automatic sample_cycle();
        string          tag;
        int             due;
        logic [1:0]     exp_flags;
        @(negedge clk);
        tag = $sformatf("test%0d", test_idx);
        if (hold_vd) begin
            check_value({tag, " held instr_vd"}, 34'd1, instr_vd);
            check_value({tag, " held instr"}, held_instr, instr);
        end
        hold_vd    = instr_vd & ~idu_rdy & ~new_pc_req & ~stop_fetch;
        held_instr = instr;
        if (idle_chk) begin
            check_value({tag, " stopped ifu_busy"}, 34'd0, ifu_busy);
            check_value({tag, " stopped imem_req"}, 34'd0, imem_req);
            check_value({tag, " stopped instr_vd"}, 34'd0, instr_vd);
        end
        if (new_pc_req) begin
            next_addr = {new_pc[`IFU_XLEN-1:2], 2'b00};    // Word holding the target
        end
        if (imem_req && imem_req_ack) begin
            check_value({tag, " imem_addr"}, next_addr, imem_addr);
            next_addr = next_addr + 32'd4;
            due = cycle_cnt + 1 + int'(next_rand() % 3);    // 1 to 3 cycles later
            if (due <= last_due) begin
                due = last_due + 1;                         // Keep answers in order
            end
            last_due = due;
            pend_due.push_back(due);
            pend_addr.push_back(imem_addr);
        end
        if (instr_vd && idu_rdy && got < exp_cnt) begin
            exp_flags = vec[exp_base + 2 * got + 1][1:0];
            tag = $sformatf("test%0d instr%0d", test_idx, got);
            check_value({tag, " instr"}, vec[exp_base + 2 * got], instr.instr);
            check_value({tag, " imem_err"}, exp_flags[1], instr.imem_err);
            check_value({tag, " err_rvi_hi"}, exp_flags[0], instr.err_rvi_hi);
            if (exp_flags[1]) begin
                check_value({tag, " ifu_busy"}, 34'd0, ifu_busy);  // FSM left fetch
            end
            got++;
        end
    endtask

    //----------------------------------------------------------------
    // Rising edge, then drive memory model and decode inputs
    //----------------------------------------------------------------
    task automatic advance_cycle();
        logic [14:0] r;
        @(posedge clk);
        cycle_cnt++;
        if (cycle_cnt > cycle_limit) begin
            abort_run($sformatf("timeout after %0d cycles, instructions missing", cycle_cnt));
        end
        #2;
        new_pc_req = 1'b0;
        stop_fetch = 1'b0;
        r = next_rand();
        imem_req_ack = |r[1:0];                     // Ack three times in four
        r = next_rand();
        idu_rdy = |r[1:0];
        imem_resp = '0;
        if (pend_due.size() > 0 && pend_due[0] <= cycle_cnt) begin
            if (pend_addr[0] == err_addr) begin
                imem_resp.resp = ifu_pkg::resp_rdy_er;
            end else begin
                imem_resp.resp  = ifu_pkg::resp_rdy_ok;
                imem_resp.rdata = vec[pend_addr[0][5:2]];
            end
            void'(pend_due.pop_front());
            void'(pend_addr.pop_front());
        end
    endtask

    task automatic run_cycle();
        sample_cycle();
        advance_cycle();
    endtask

    initial begin
        int             pos;
        int             total;
        int             num_tests;
        logic [31:0]    first_pc;
        rst_n        = 1'b0;
        new_pc_req   = 1'b0;
        new_pc       = '0;
        stop_fetch   = 1'b0;
        imem_req_ack = 1'b0;
        imem_resp    = '0;
        idu_rdy      = 1'b0;
        lcg_state    = 9160;
        cycle_cnt    = 0;
        cycle_limit  = 0;
        last_due     = 0;
        hold_vd      = 1'b0;
        held_instr   = '0;
        idle_chk     = 1'b0;
        test_idx     = 0;
        exp_base     = 0;
        exp_cnt      = 0;
        got          = 0;
        err_addr     = no_addr;
        next_addr    = '0;
        $readmemh("tests/ifu_input.txt", vec);
        if ($isunknown(vec[16])) begin
            abort_run("input file missing or incomplete");
        end
        num_tests = vec[16];
        pos   = 17;
        total = 0;
        for (int t = 0; t < num_tests; t++) begin
            total += vec[pos + 3];
            pos   += 4 + 2 * vec[pos + 3];
        end
        cycle_limit = 40 * total;

        repeat (2) @(posedge clk);
        #2;
        rst_n = 1'b1;
        @(negedge clk);
        check_value("reset imem_req", 34'd0, imem_req);
        check_value("reset ifu_busy", 34'd0, ifu_busy);
        check_value("reset instr_vd", 34'd0, instr_vd);
        advance_cycle();

        pos = 17;
        for (int t = 0; t < num_tests; t++) begin
            test_idx = t;
            first_pc = vec[pos + 1];
            err_addr = vec[pos + 2];
            exp_cnt  = vec[pos + 3];
            exp_base = pos + 4;
            got      = 0;
            if (first_pc != no_addr) begin
                new_pc_req   = 1'b1;                // Jump that gets overridden
                new_pc       = first_pc;
                imem_req_ack = 1'b1;                // Leaves its answer in flight
                run_cycle();
            end
            new_pc_req = 1'b1;
            new_pc     = vec[pos];
            pos        = exp_base + 2 * exp_cnt;
            while (got < exp_cnt) begin
                run_cycle();
            end
            stop_fetch = 1'b1;
            run_cycle();
            idle_chk = 1'b1;
            repeat (12) run_cycle();
            idle_chk = 1'b0;
        end
        $display("Finished with no errors");
        $finish;
    end

endmodule : ifu_tb

`default_nettype wire

/* sources.f */
+incdir+logic
logic/ifu_pkg.sv
logic/fetch_req_ctrl.sv
logic/rdata_classifier.sv
logic/instr_queue.sv
logic/ifu_top.sv
tests/ifu_tb.sv

/* tests/ifu_input.txt */
// Words 0-15: memory image at byte address 4*n. Word 16: number of tests.
// Test: target, first jump (ffffffff none), error address (ffffffff none), count,
// then per instruction: expected instruction, flags (bit 1 imem_err, bit 0 err_rvi_hi)
00934501 45850010 00B58533 01130505
90020FF0 03134601 80820050 22231141
468100A1 05134705 47A90030 00C50593
06B38526 000100D5 47814701 00010001
00000006
// Aligned mixed stream with straddling RVI
00000000 FFFFFFFF FFFFFFFF 0000000A
00004501 0 00100093 0 00004585 0 00B58533 0
00000505 0 0FF00113 0 00009002 0 00004601 0
00500313 0 00008082 0
// Unaligned jump onto an RVI first half
0000000E FFFFFFFF FFFFFFFF 00000004
0FF00113 0 00009002 0 00004601 0 00500313 0
// Unaligned jump onto an RVC
0000001A FFFFFFFF FFFFFFFF 00000004
00008082 0 00001141 0 00A12223 0 00004681 0
// Second jump one cycle after the first
00000024 00000000 FFFFFFFF 00000007
00004705 0 00300513 0 000047A9 0 00C50593 0
00008526 0 00D506B3 0 00000001 0
// Access error on an aligned word
00000000 FFFFFFFF 00000008 00000004
00004501 0 00100093 0 00004585 0 00000000 2
// Access error on the second half of an RVI
0000000C FFFFFFFF 00000010 00000002
00000505 0 00000113 3
